// File: hw/stepper_defines.svh
/*
  stepper controller constants
  address map, RAM depth, step timing and SPI clock divider
*/
`ifndef STEPPER_DEFINES_SVH
`define STEPPER_DEFINES_SVH

// RAM window 0x1000 .. 0x1fff
`define RAM_BASE 32'h0000_1000
`define RAM_WORDS 1024

// IO register block, eight word registers
`define IO_BASE 32'h1000_0000

// step timing in clock cycles
`define STEP_PRESCALE 16
`define STEP_PULSE_CYCLES 8

// clocks per SCK half period
`define SPI_CLK_DIV 4

`endif

// File: hw/stepper_pkg.sv
/*
  stepper controller types
  bus request, motor configuration and the 40-bit driver datagram,
  which reads as a command on the way out and a reply on the way in
*/
`default_nettype none

package stepper_pkg;

  // picorv32 native bus request, wstrb == 0 means read
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } mem_req_t;

  // motor settings from the ctrl and period registers
  typedef struct packed {
    logic        step_en;
    logic        dir;
    logic        drv_en;
    logic [15:0] period;
  } motor_cfg_t;

  // datagram as sent to the driver chip
  typedef struct packed {
    logic        wr;
    logic [6:0]  addr;
    logic [31:0] data;
  } spi_cmd_t;

  // datagram as returned by the driver chip
  typedef struct packed {
    logic [7:0]  status;
    logic [31:0] data;
  } spi_reply_t;

  typedef union packed {
    spi_cmd_t   cmd;
    spi_reply_t reply;
  } spi_frame_u;

endpackage

`default_nettype wire

// File: hw/bus_decoder.sv
/*
  bus decoder
  routes each access to RAM or IO, steers the read data back
  and answers unmapped addresses with zero
*/
`default_nettype none
`include "stepper_defines.svh"

module bus_decoder import stepper_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        mem_valid,
  input  mem_req_t    mem_req,
  output logic        ram_sel,
  output logic        io_sel,
  input  logic        ram_ready,
  input  logic        io_ready,
  input  logic [31:0] ram_rdata,
  input  logic [31:0] io_rdata,
  output logic        mem_ready,
  output logic [31:0] mem_rdata
);

  logic ram_hit;
  logic io_hit;
  logic ram_sel_q;
  logic io_sel_q;
  logic unm_ready;

  // address windows
  assign ram_hit = (mem_req.addr >= `RAM_BASE) &&
                   (mem_req.addr < (`RAM_BASE + `RAM_WORDS * 4));
  assign io_hit  = (mem_req.addr & ~32'h1f) == `IO_BASE;

  assign ram_sel = mem_valid && ram_hit;
  assign io_sel  = mem_valid && io_hit;

  // select of last cycle steers read data, unmapped gets own ready
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      ram_sel_q <= 1'b0;
      io_sel_q  <= 1'b0;
      unm_ready <= 1'b0;
    end else begin
      ram_sel_q <= ram_sel;
      io_sel_q  <= io_sel;
      unm_ready <= mem_valid && !ram_hit && !io_hit && !unm_ready;
    end
  end

  assign mem_ready = ram_ready || io_ready || unm_ready;
  assign mem_rdata = ram_sel_q ? ram_rdata : (io_sel_q ? io_rdata : 32'h0);

  // one-hot target select
  assert property (@(posedge clk_in) disable iff (!rst_n) !(ram_sel && io_sel));
  // every target answers with a single-cycle ready
  assert property (@(posedge clk_in) disable iff (!rst_n) mem_ready |=> !mem_ready);

endmodule

`default_nettype wire

// File: hw/sram_bank.sv
/*
  RAM bank
  single-port word memory with byte strobes, ready one cycle after accept
*/
`default_nettype none
`include "stepper_defines.svh"

module sram_bank import stepper_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        sel,
  input  mem_req_t    mem_req,
  output logic        ready,
  output logic [31:0] rdata
);

  localparam int AW = $clog2(`RAM_WORDS);

  logic [31:0]   mem [`RAM_WORDS];
  logic [31:0]   offs;
  logic [AW-1:0] idx;
  logic          accept;

  // word index inside the bank
  assign offs   = mem_req.addr - `RAM_BASE;
  assign idx    = offs[AW+1:2];
  // ready high blocks a second access in the overlap cycle
  assign accept = sel && !ready;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) ready <= 1'b0;
    else        ready <= accept;
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_req.wstrb[b]) mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
      end
      // read word, held until next access
      if (mem_req.wstrb == 4'h0) rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// File: hw/io_regs.sv
/*
  IO register block
  LEDs, motor settings, step count readback and the SPI command/reply
  path; a transfer request stalls the bus while the SPI master is busy
*/
`default_nettype none

module io_regs import stepper_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        sel,
  input  mem_req_t    mem_req,
  output logic        ready,
  output logic [31:0] rdata,
  output logic [7:0]  led,
  output motor_cfg_t  motor_cfg,
  input  logic [31:0] step_count,
  output spi_frame_u  spi_cmd,
  output logic        spi_start,
  input  logic        spi_busy,
  input  spi_frame_u  spi_reply
);

  logic [2:0]  offs;
  logic        is_write;
  logic        spi_go;
  logic        accept;
  logic [31:0] spi_data;
  logic [31:0] rd_word;

  assign offs     = mem_req.addr[4:2];
  assign is_write = mem_req.wstrb != 4'h0;
  assign spi_go   = is_write && (offs == 3'd4);
  // hold a new transfer until the previous frame is done
  assign accept   = sel && !ready && !(spi_go && (spi_busy || spi_start));

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      ready     <= 1'b0;
      spi_start <= 1'b0;
    end else begin
      ready     <= accept;
      spi_start <= accept && spi_go;
    end
  end

  // configuration registers
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      motor_cfg <= '0;
      led       <= '0;
      spi_data  <= '0;
    end else if (accept && is_write) begin
      case (offs)
        3'd0: begin
          motor_cfg.step_en <= mem_req.wdata[0];
          motor_cfg.dir     <= mem_req.wdata[1];
          motor_cfg.drv_en  <= mem_req.wdata[2];
        end
        3'd1: motor_cfg.period <= mem_req.wdata[15:0];
        3'd2: led <= mem_req.wdata[7:0];
        3'd3: spi_data <= mem_req.wdata;
        default: ;
      endcase
    end
  end

  // frame assembled at start, data word comes from the spi data register
  always_ff @(posedge clk_in) begin
    if (accept && spi_go) begin
      spi_cmd.cmd.wr   <= mem_req.wdata[7];
      spi_cmd.cmd.addr <= mem_req.wdata[6:0];
      spi_cmd.cmd.data <= spi_data;
    end
  end

  always_comb begin
    case (offs)
      3'd0:    rd_word = {29'h0, motor_cfg.drv_en, motor_cfg.dir, motor_cfg.step_en};
      3'd1:    rd_word = {16'h0, motor_cfg.period};
      3'd2:    rd_word = {24'h0, led};
      3'd3:    rd_word = spi_data;
      3'd4:    rd_word = {24'h0, spi_cmd.cmd.wr, spi_cmd.cmd.addr};
      3'd5:    rd_word = spi_reply.reply.data;
      3'd6:    rd_word = {16'h0, spi_reply.reply.status, 7'h0, spi_busy};
      default: rd_word = step_count;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (accept && !is_write) rdata <= rd_word;
  end

  // firmware only does word stores to IO
  assert property (@(posedge clk_in) disable iff (!rst_n)
    (accept && is_write) |-> (mem_req.wstrb == 4'hf));

endmodule

`default_nettype wire

// File: hw/step_generator.sv
/*
  step generator
  prescaled period counter, fixed-width step pulses, step counter
  and registered direction / driver enable pins
*/
`default_nettype none
`include "stepper_defines.svh"

module step_generator import stepper_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  input  motor_cfg_t  motor_cfg,
  output logic        step,
  output logic        dir,
  output logic        drv_en_n,
  output logic [31:0] step_count
);

  localparam int PS_W = $clog2(`STEP_PRESCALE);
  localparam int PW_W = $clog2(`STEP_PULSE_CYCLES);

  logic [PS_W-1:0] pre_cnt;
  logic [15:0]     per_cnt;
  logic [15:0]     period_q;
  logic [PW_W-1:0] pw_cnt;
  logic            run;
  logic            tick;
  logic            boundary;

  assign run      = motor_cfg.step_en && (motor_cfg.period != 16'h0);
  assign tick     = pre_cnt == PS_W'(`STEP_PRESCALE - 1);
  // last prescaled tick of the period
  assign boundary = tick && (per_cnt == period_q - 16'd1);

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      pre_cnt    <= '0;
      per_cnt    <= '0;
      period_q   <= '0;
      pw_cnt     <= '0;
      step       <= 1'b0;
      step_count <= '0;
    end else if (!run) begin
      // idle, pick up the period for the next start
      pre_cnt  <= '0;
      per_cnt  <= '0;
      period_q <= motor_cfg.period;
      pw_cnt   <= '0;
      step     <= 1'b0;
    end else begin
      pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
      if (boundary) begin
        per_cnt    <= '0;
        period_q   <= motor_cfg.period;
        step       <= 1'b1;
        pw_cnt     <= PW_W'(`STEP_PULSE_CYCLES - 1);
        step_count <= step_count + 32'd1;
      end else begin
        if (tick) per_cnt <= per_cnt + 16'd1;
        // pulse width countdown
        if (step) begin
          if (pw_cnt == '0) step <= 1'b0;
          else              pw_cnt <= pw_cnt - 1'b1;
        end
      end
    end
  end

  // pins, driver enable is active low
  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      dir      <= 1'b0;
      drv_en_n <= 1'b1;
    end else begin
      dir      <= motor_cfg.dir;
      drv_en_n <= !motor_cfg.drv_en;
    end
  end

endmodule

`default_nettype wire

// File: hw/spi_master.sv
/*
  SPI master for the stepper driver chip
  mode 3, 40-bit frames MSB first, reply kept until the next transfer
*/
`default_nettype none
`include "stepper_defines.svh"

module spi_master import stepper_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_n,
  input  logic       start,
  input  spi_frame_u cmd,
  output logic       busy,
  output spi_frame_u reply,
  output logic       sck,
  output logic       mosi,
  output logic       cs_n,
  input  logic       miso
);

  localparam int DIV_W = $clog2(`SPI_CLK_DIV);
  localparam logic [6:0] FRAME_EDGES = 7'd80;

  logic [DIV_W-1:0] div_cnt;
  logic [6:0]       edge_cnt;
  logic [39:0]      tx_sr;
  logic [39:0]      rx_sr;
  logic             half_tick;
  logic             edge_go;
  logic             fall_go;
  logic             rise_go;

  assign half_tick = busy && (div_cnt == DIV_W'(`SPI_CLK_DIV - 1));
  assign edge_go   = half_tick && (edge_cnt != FRAME_EDGES);
  // sck high now means the next edge falls
  assign fall_go   = edge_go && sck;
  assign rise_go   = edge_go && !sck;

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      cs_n     <= 1'b1;
      sck      <= 1'b1;
      mosi     <= 1'b1;
      div_cnt  <= '0;
      edge_cnt <= '0;
      reply    <= '0;
    end else if (start) begin
      // first falling edge together with cs_n
      busy     <= 1'b1;
      cs_n     <= 1'b0;
      sck      <= 1'b0;
      mosi     <= cmd[39];
      div_cnt  <= '0;
      edge_cnt <= 7'd1;
    end else if (busy) begin
      div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
      if (edge_go) begin
        sck      <= !sck;
        edge_cnt <= edge_cnt + 7'd1;
      end
      if (fall_go) mosi <= tx_sr[39];
      // tail half period after the last rising edge
      if (half_tick && !edge_go) begin
        cs_n  <= 1'b1;
        busy  <= 1'b0;
        reply <= rx_sr;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (start)   tx_sr <= {cmd[38:0], 1'b0};
    if (fall_go) tx_sr <= {tx_sr[38:0], 1'b0};
    if (rise_go) rx_sr <= {rx_sr[38:0], miso};
  end

  assert property (@(posedge clk_in) disable iff (!rst_n) start |-> !busy);

endmodule

`default_nettype wire

// File: hw/stepper_top.sv
/*
  stepper controller top
  bus decoder, RAM, IO registers, step generator and SPI master
*/
`default_nettype none

module stepper_top import stepper_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        mem_valid,
  input  mem_req_t    mem_req,
  output logic        mem_ready,
  output logic [31:0] mem_rdata,
  output logic [7:0]  led,
  output logic        step,
  output logic        dir,
  output logic        drv_en_n,
  output logic        spi_sck,
  output logic        spi_mosi,
  output logic        spi_cs_n,
  input  logic        spi_miso
);

  logic        ram_sel, io_sel;
  logic        ram_ready, io_ready;
  logic [31:0] ram_rdata, io_rdata;
  motor_cfg_t  motor_cfg;
  logic [31:0] step_count;
  spi_frame_u  spi_cmd, spi_reply;
  logic        spi_start, spi_busy;

  bus_decoder decoder_i (.clk_in, .rst_n, .mem_valid, .mem_req, .ram_sel, .io_sel,
    .ram_ready, .io_ready, .ram_rdata, .io_rdata, .mem_ready, .mem_rdata);

  sram_bank ram_i (.clk_in, .rst_n, .sel(ram_sel), .mem_req, .ready(ram_ready),
    .rdata(ram_rdata));

  io_regs io_i (.clk_in, .rst_n, .sel(io_sel), .mem_req, .ready(io_ready), .rdata(io_rdata),
    .led, .motor_cfg, .step_count, .spi_cmd, .spi_start, .spi_busy, .spi_reply);

  step_generator step_i (.clk_in, .rst_n, .motor_cfg, .step, .dir, .drv_en_n, .step_count);

  // driver chip link
  spi_master spi_i (.clk_in, .rst_n, .start(spi_start), .cmd(spi_cmd), .busy(spi_busy),
    .reply(spi_reply), .sck(spi_sck), .mosi(spi_mosi), .cs_n(spi_cs_n), .miso(spi_miso));

endmodule

`default_nettype wire

// File: verif/stepper_tb.sv
/*
  stepper controller testbench
  plays the bus master, models the driver chip on the SPI link and
  checks RAM, IO registers, step timing and SPI transfers
*/
`default_nettype none
`include "stepper_defines.svh"

module stepper_tb import stepper_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'd53874;
  localparam int BUS_TIMEOUT = 2000;
  localparam int WAIT_TIMEOUT = 3000;
  localparam int POLL_LIMIT = 200;

  // IO register addresses
  localparam logic [31:0] CTRL = `IO_BASE + 32'h00;
  localparam logic [31:0] PERIOD = `IO_BASE + 32'h04;
  localparam logic [31:0] LED = `IO_BASE + 32'h08;
  localparam logic [31:0] SPI_DATA = `IO_BASE + 32'h0c;
  localparam logic [31:0] SPI_ADDR = `IO_BASE + 32'h10;
  localparam logic [31:0] REPLY = `IO_BASE + 32'h14;
  localparam logic [31:0] STATUS = `IO_BASE + 32'h18;
  localparam logic [31:0] COUNT = `IO_BASE + 32'h1c;

  logic        clk_in, rst_n, mem_valid, mem_ready;
  logic        spi_miso = 1'b1;
  mem_req_t    mem_req;
  logic [31:0] mem_rdata;
  logic [7:0]  led;
  logic        step, dir, drv_en_n, spi_sck, spi_mosi, spi_cs_n;

  logic [31:0] rng = SEED;
  int          errors = 0;
  int          checks = 0;
  int          tests = 0;
  int          test_err0 = 0;
  int          last_lat;
  logic [31:0] last_rdata;
  logic        cs_high_seen;

  // step monitor state
  int          cyc = 0;
  int          rises = 0;
  int          last_rise = 0;
  int          high_len = 0;
  logic        have_rise = 1'b0;
  logic        step_q = 1'b0;
  int          step_gaps[$];
  int          widths[$];

  // driver chip model state
  logic        cs_q = 1'b1;
  logic        sck_q = 1'b1;
  logic [39:0] tx_sr, rx_sr;
  int          rise_cnt, low_cnt;
  logic [39:0] frames[$];
  // reply as if a zero frame came before the first one
  logic [39:0] reply_next = {8'ha5, 32'hffff_ffff};

  stepper_top dut_i (.clk_in, .rst_n, .mem_valid, .mem_req, .mem_ready, .mem_rdata, .led,
    .step, .dir, .drv_en_n, .spi_sck, .spi_mosi, .spi_cs_n, .spi_miso);

  always #10 clk_in = ~clk_in;

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_equal(input logic [39:0] got, input logic [39:0] exp,
                             input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %0t: %s got 0x%h expected 0x%h", $time, what, got, exp);
    end
  endtask

  // one access from a falling edge, held until mem_ready
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb);
    // one cycle with mem_valid low between accesses
    @(negedge clk_in);
    last_lat = 0;
    cs_high_seen = 1'b0;
    mem_valid = 1'b1;
    mem_req.addr = addr;
    mem_req.wdata = wdata;
    mem_req.wstrb = wstrb;
    do begin
      @(negedge clk_in);
      last_lat++;
      if (spi_cs_n) cs_high_seen = 1'b1;
    end while (!mem_ready && last_lat < BUS_TIMEOUT);
    last_rdata = mem_rdata;
    mem_valid = 1'b0;
    mem_req.wstrb = 4'h0;
    if (!mem_ready) begin
      errors++;
      $display("bus access to 0x%h got no ready within %0d cycles", addr, BUS_TIMEOUT);
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    bus_access(addr, data, 4'hf);
  endtask

  task automatic read_word(input logic [31:0] addr);
    bus_access(addr, 32'h0, 4'h0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk_in);
  endtask

  task automatic wait_rises(input int target);
    int t;
    t = 0;
    while (rises < target && t < WAIT_TIMEOUT) begin
      @(negedge clk_in);
      t++;
    end
    if (rises < target) begin
      errors++;
      $display("step pulses stopped, saw %0d of %0d rising edges", rises, target);
    end
  endtask

  task automatic expect_frame(input logic [39:0] exp);
    int t;
    t = 0;
    while (frames.size() == 0 && t < WAIT_TIMEOUT) begin
      @(negedge clk_in);
      t++;
    end
    if (frames.size() == 0) begin
      errors++;
      $display("no SPI frame reached the driver chip within %0d cycles", WAIT_TIMEOUT);
    end else begin
      check_equal(frames.pop_front(), exp, "frame at driver chip");
    end
  endtask

  // status polled until busy clears, then reply of the frame sent before
  task automatic check_reply(input logic [7:0] prev_byte, input logic [31:0] prev_data);
    int n;
    logic [7:0] exp_status;
    logic [31:0] exp_data;
    n = 0;
    exp_status = 8'ha5 ^ prev_byte;
    exp_data = ~prev_data;
    do begin
      read_word(STATUS);
      n++;
    end while (last_rdata[0] && n < POLL_LIMIT);
    if (last_rdata[0]) begin
      errors++;
      $display("SPI still busy after %0d status reads", n);
    end
    check_equal(last_rdata[15:8], exp_status, "reply status");
    read_word(REPLY);
    check_equal(last_rdata, exp_data, "reply data");
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - test_err0);
    test_err0 = errors;
  endtask

  // step edges and pulse widths, sampled before the clock edge updates
  always @(posedge clk_in) begin
    if (rst_n) begin
      cyc++;
      if (step && !step_q) begin
        rises++;
        if (have_rise) step_gaps.push_back(cyc - last_rise);
        last_rise = cyc;
        have_rise = 1'b1;
      end
      if (step) high_len++;
      if (!step && step_q) begin
        widths.push_back(high_len);
        high_len = 0;
      end
      step_q = step;
    end
  end

  // driver chip, mode 3, reply carries the previous frame's result
  always @(negedge clk_in) begin
    if (!rst_n) begin
      spi_miso <= 1'b1;
    end else begin
      if (cs_q && !spi_cs_n) begin
        tx_sr = reply_next;
        rx_sr = '0;
        rise_cnt = 0;
        low_cnt = 0;
        spi_miso <= reply_next[39];
      end else if (!spi_cs_n && !sck_q && spi_sck) begin
        rx_sr = {rx_sr[38:0], spi_mosi};
        rise_cnt++;
      end else if (!spi_cs_n && sck_q && !spi_sck) begin
        tx_sr = tx_sr << 1;
        spi_miso <= tx_sr[39];
      end
      if (!spi_cs_n) low_cnt++;
      if (!cs_q && spi_cs_n) begin
        check_equal(rise_cnt, 40, "SCK periods in frame");
        check_equal(low_cnt, 80 * `SPI_CLK_DIV, "cs_n low cycles");
        frames.push_back(rx_sr);
        reply_next = {8'ha5 ^ rx_sr[39:32], ~rx_sr[31:0]};
      end
      cs_q = spi_cs_n;
      sck_q = spi_sck;
    end
  end

  // SCK idles high whenever the chip is deselected
  assert property (@(posedge clk_in) disable iff (!rst_n) spi_cs_n |-> spi_sck)
    else begin
      errors++;
      $display("Fail %0t: SCK low while cs_n high", $time);
    end

  initial begin
    logic [31:0] shadow [`RAM_WORDS];
    logic        known [`RAM_WORDS];
    int          ram_idx [8];
    int          idx, per;
    int          e0, e1, e2;
    logic [31:0] r, addr, c0, c1, c2, ctrl_v, per_v, led_v, sdata, sdata2;
    logic [3:0]  strb;
    logic [7:0]  sbyte, sbyte2, prev_byte;
    logic [31:0] prev_data;

    clk_in = 1'b0;
    rst_n = 1'b0;
    mem_valid = 1'b0;
    mem_req = '0;
    for (int k = 0; k < `RAM_WORDS; k++) known[k] = 1'b0;
    repeat (3) @(posedge clk_in);
    @(negedge clk_in);
    rst_n = 1'b1;

    // reset state of pins and registers
    check_equal(mem_ready, 1'b0, "mem_ready after reset");
    check_equal(step, 1'b0, "step after reset");
    check_equal({spi_cs_n, spi_sck}, 2'b11, "cs_n and sck after reset");
    check_equal(drv_en_n, 1'b1, "drv_en_n after reset");
    check_equal(led, 8'h0, "led after reset");
    read_word(CTRL);
    check_equal(last_rdata, 32'h0, "ctrl after reset");
    read_word(PERIOD);
    check_equal(last_rdata, 32'h0, "period after reset");
    end_test("reset state");

    // random strobes on a few random words, shadow kept per byte
    for (int k = 0; k < 8; k++) ram_idx[k] = int'(next_rand() & (`RAM_WORDS - 1));
    for (int k = 0; k < 40; k++) begin
      r = next_rand();
      idx = ram_idx[r[2:0]];
      addr = `RAM_BASE + 32'(idx) * 4;
      sdata = next_rand();
      strb = known[idx] ? r[7:4] : 4'hf;
      if (strb == 4'h0) strb = 4'h1;
      bus_access(addr, sdata, strb);
      check_equal(last_lat, 1, "RAM write latency");
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) shadow[idx][8*b +: 8] = sdata[8*b +: 8];
      end
      known[idx] = 1'b1;
      read_word(addr);
      check_equal(last_lat, 1, "RAM read latency");
      check_equal(last_rdata, shadow[idx], $sformatf("RAM word at 0x%h", addr));
    end
    end_test("RAM byte strobes");

    // unmapped read and IO readback
    r = next_rand();
    read_word(r & 32'h0000_0ffc);
    check_equal(last_lat, 1, "unmapped latency");
    check_equal(last_rdata, 32'h0, "unmapped read data");
    ctrl_v = next_rand() & 32'h6;
    per_v = next_rand() & 32'hffff;
    led_v = next_rand() & 32'hff;
    write_word(CTRL, ctrl_v);
    write_word(PERIOD, per_v);
    write_word(LED, led_v);
    read_word(CTRL);
    check_equal(last_rdata, ctrl_v, "ctrl readback");
    read_word(PERIOD);
    check_equal(last_rdata, per_v, "period readback");
    read_word(LED);
    check_equal(last_rdata, led_v, "led readback");
    check_equal(led, led_v[7:0], "led port");
    end_test("unmapped and readback");

    // step spacing and width for a random period
    per = int'(next_rand() & 32'h7) + 1;
    write_word(PERIOD, 32'(per));
    step_gaps.delete();
    widths.delete();
    have_rise = 1'b0;
    ctrl_v = (next_rand() & 32'h6) | 32'h1;
    write_word(CTRL, ctrl_v);
    wait_rises(rises + 5);
    foreach (step_gaps[k]) check_equal(step_gaps[k], per * `STEP_PRESCALE, "step spacing");
    foreach (widths[k]) check_equal(widths[k], `STEP_PULSE_CYCLES, "step pulse width");
    check_equal(dir, ctrl_v[1], "dir pin");
    check_equal(drv_en_n, !ctrl_v[2], "drv_en_n pin");
    end_test("step timing");

    // count register against counted edges, then stop
    read_word(COUNT);
    c0 = last_rdata;
    e0 = rises;
    wait_rises(rises + 3);
    read_word(COUNT);
    c1 = last_rdata;
    e1 = rises;
    check_equal(c1 - c0, 32'(e1 - e0), "step count while running");
    write_word(CTRL, ctrl_v & 32'h6);
    read_word(COUNT);
    c2 = last_rdata;
    e2 = rises;
    check_equal(c2 - c1, 32'(e2 - e1), "step count at stop");
    idle_cycles(3 * per * `STEP_PRESCALE + 20);
    check_equal(rises, e2, "edges after stop");
    check_equal(step, 1'b0, "step low after stop");
    read_word(COUNT);
    check_equal(last_rdata, c2, "step count held");
    end_test("step count and stop");

    // two plain transfers
    prev_byte = 8'h0;
    prev_data = 32'h0;
    for (int k = 0; k < 2; k++) begin
      sdata = next_rand();
      r = next_rand();
      sbyte = r[7:0];
      write_word(SPI_DATA, sdata);
      write_word(SPI_ADDR, {24'h0, sbyte});
      expect_frame({sbyte, sdata});
      check_reply(prev_byte, prev_data);
      prev_byte = sbyte;
      prev_data = sdata;
    end
    end_test("SPI transfer");

    // second start while the first frame is still shifting
    sdata = next_rand();
    r = next_rand();
    sbyte = r[7:0];
    write_word(SPI_DATA, sdata);
    write_word(SPI_ADDR, {24'h0, sbyte});
    idx = 0;
    while (spi_cs_n && idx < WAIT_TIMEOUT) begin
      @(negedge clk_in);
      idx++;
    end
    if (spi_cs_n) begin
      errors++;
      $display("cs_n never went low for the first frame");
    end
    sdata2 = next_rand();
    r = next_rand();
    sbyte2 = r[7:0];
    write_word(SPI_DATA, sdata2);
    write_word(SPI_ADDR, {24'h0, sbyte2});
    check_equal(cs_high_seen, 1'b1, "ready held until cs_n high");
    check_equal(last_lat > 1, 1'b1, "stalled write latency");
    expect_frame({sbyte, sdata});
    expect_frame({sbyte2, sdata2});
    check_reply(sbyte, sdata);
    end_test("SPI back-pressure");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/stepper_pkg.sv
hw/bus_decoder.sv
hw/sram_bank.sv
hw/io_regs.sv
hw/step_generator.sv
hw/spi_master.sv
hw/stepper_top.sv
verif/stepper_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the stepper controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f project.f --top-module stepper_tb

./obj_dir/Vstepper_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TEST OK" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
